// File: Makefile
VERILATOR ?= verilator
TOP ?= mbcTb
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wall -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(wildcard source/*.sv bench/*.sv bench/*.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/mbcRef.svh
// Reference model functions for memory address parity, word address stepping and phase strobes.
`ifndef MBC_REF_SVH
`define MBC_REF_SVH

// Parity over the held request, with the forced bad-parity flag folded in.
function automatic logic refParity(
  input logic parIn,
  input logic rdRq,
  input logic wrRq,
  input mbcPkg::rqMaskT mask,
  input mbcPkg::wordAdrT adr,
  input logic forceBad
);
  logic p;
  p = parIn ^ rdRq ^ wrRq ^ forceBad;
  for (int i = 0; i < mbcPkg::RqWords; i++) begin
    p = p ^ mask[i];
  end
  p = p ^ adr[0] ^ adr[1];
  return p;
endfunction

// Core word address after one word, wrapping inside the quad-word.
function automatic mbcPkg::wordAdrT refNextAdr(input mbcPkg::wordAdrT adr);
  int next;
  next = (int'(adr) + 1) % mbcPkg::RqWords;
  return mbcPkg::wordAdrT'(next);
endfunction

// Number of words asked for by a request mask.
function automatic int countWords(input mbcPkg::rqMaskT mask);
  int n;
  n = 0;
  for (int i = 0; i < mbcPkg::RqWords; i++) begin
    n += mask[i];
  end
  return n;
endfunction

// Expected {aChangeComing, bChangeComing} in a cycle.
// The strobes repeat every two half-phases, starting from the first one seen.
function automatic logic [1:0] refStrobe(
  input int cyc,
  input int firstCyc,
  input logic firstIsA
);
  int d;
  if (firstCyc < 0 || cyc < firstCyc) begin
    return 2'b00;
  end
  d = (cyc - firstCyc) % (4 * mbcPkg::PhaseLen / 2);
  if (d == 0) begin
    return firstIsA ? 2'b10 : 2'b01;
  end else if (d == mbcPkg::PhaseLen) begin
    return firstIsA ? 2'b01 : 2'b10;
  end
  return 2'b00;
endfunction

`endif

// File: bench/mbcTb.sv
// Testbench for the memory bus control top with phase, start, hold, parity and core read checks.
`timescale 1ns/1ps

module mbcTb;

  localparam int NumTxn = 12;
  localparam int TxnCycles = 40;
  localparam int Margin = 200;
  localparam int ClkPeriod = 8;

  logic clk = 1'b0;
  logic arstN;
  logic coreRdRq, startMem, anyRqIn, rdRqIn, wrRqIn;
  mbcPkg::rqMaskT rqIn;
  mbcPkg::wordAdrT sbusAdr;
  logic adrParIn, wrBadAdrPar;
  logic memAcknA, memAcknB, nxmAckn;
  logic memDataValidA, memDataValidB, nxmDataVal;
  logic memStartA, memStartB, acknPulse, memAdrPar;
  logic coreDataValid, coreRdInProg;
  mbcPkg::wordAdrT coreAdr;
  logic aChangeComing, bChangeComing;
  mbcPkg::rqMaskT memRq;
  logic memRdRq, memWrRq;

  // Expected held request, tracked one clock ahead of the DUT.
  mbcPkg::rqMaskT mRq;
  mbcPkg::wordAdrT mAdr;
  logic mRd, mWr, mPar, mForce;
  logic [1:0] dvHist = 2'b00;
  int cyc = 0;
  int firstStrobe = -1;
  logic firstIsA = 1'b0;

  `include "mbcRef.svh"

  mbcTop dut (.*);

  always #(ClkPeriod / 2) clk = ~clk;

  task automatic checkBit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
      $display("Simulation FAILED");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic checkMask(input string name, input mbcPkg::rqMaskT got,
                           input mbcPkg::rqMaskT exp);
    if (got !== exp) begin
      $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
      $display("Simulation FAILED");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic checkAdr(input string name, input mbcPkg::wordAdrT got,
                          input mbcPkg::wordAdrT exp);
    if (got !== exp) begin
      $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
      $display("Simulation FAILED");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // Compares the DUT with the reference every cycle, away from the driving edge.
  always @(negedge clk) begin
    logic [1:0] exp;
    logic qual;
    logic ms;
    cyc++;
    ms = memStartA | memStartB;
    if (!arstN) begin
      checkBit("memStartA", memStartA, 1'b0);
      checkBit("memStartB", memStartB, 1'b0);
      checkBit("coreDataValid", coreDataValid, 1'b0);
      checkBit("coreRdInProg", coreRdInProg, 1'b0);
    end else if (cyc > 2) begin
      checkMask("memRq", memRq, mRq);
      checkBit("memRdRq", memRdRq, mRd);
      checkBit("memWrRq", memWrRq, mWr);
      checkBit("memAdrPar", memAdrPar, refParity(mPar, mRd, mWr, mRq, mAdr, mForce));
      checkBit("memStartA & memStartB", memStartA & memStartB, 1'b0);
      checkBit("coreDataValid", coreDataValid, dvHist[1]);
      if (firstStrobe < 0 && (aChangeComing || bChangeComing)) begin
        firstStrobe = cyc;
        firstIsA = aChangeComing;
      end
      exp = refStrobe(cyc, firstStrobe, firstIsA);
      checkBit("aChangeComing", aChangeComing, exp[1]);
      checkBit("bChangeComing", bChangeComing, exp[0]);
    end
    qual = (memDataValidA | nxmDataVal) & aChangeComing |
           (memDataValidB | nxmDataVal) & bChangeComing;
    dvHist = {dvHist[0], qual & arstN};
    // The request follows the inputs unless a start holds it.
    if (!ms) begin
      mRq = rqIn;
      mRd = rdRqIn;
      mWr = wrRqIn;
      mAdr = sbusAdr;
      mPar = adrParIn;
      mForce = arstN & wrBadAdrPar;
    end
  end

  task automatic runTxn(input logic isRead);
    mbcPkg::rqMaskT mask;
    mbcPkg::wordAdrT adr;
    mbcPkg::wordAdrT expAdr;
    logic [1:0] exp;
    logic kind;
    int n;
    mask = mbcPkg::rqMaskT'($urandom_range(1, 15));
    adr = mbcPkg::wordAdrT'($urandom);
    expAdr = adr;
    n = countWords(mask);
    repeat ($urandom_range(1, 6)) @(posedge clk);
    rqIn <= mask;
    sbusAdr <= adr;
    rdRqIn <= isRead;
    wrRqIn <= !isRead;
    adrParIn <= 1'($urandom);
    wrBadAdrPar <= 1'($urandom);
    if (isRead) begin
      coreRdRq <= 1'b1;
    end else if ($urandom % 2) begin
      startMem <= 1'b1;
    end else begin
      anyRqIn <= 1'b1;
    end
    do @(negedge clk); while (!(aChangeComing || bChangeComing));
    kind = aChangeComing;
    @(negedge clk);
    checkBit("memStartA", memStartA, kind);
    checkBit("memStartB", memStartB, !kind);
    // Inputs wander while the start holds the request.
    @(posedge clk);
    coreRdRq <= 1'b0;
    startMem <= 1'b0;
    anyRqIn <= 1'b0;
    wrBadAdrPar <= 1'b0;
    rqIn <= mbcPkg::rqMaskT'($urandom);
    sbusAdr <= mbcPkg::wordAdrT'($urandom);
    rdRqIn <= 1'($urandom);
    wrRqIn <= 1'($urandom);
    @(posedge clk);
    for (int k = 1; k <= n; k++) begin
      @(posedge clk);
      exp = refStrobe(cyc + 1, firstStrobe, firstIsA);
      if ($urandom % 4 == 0) begin
        nxmAckn <= 1'b1;
      end else if (exp[1]) begin
        memAcknA <= 1'b1;
      end else begin
        memAcknB <= 1'b1;
      end
      if (isRead && $urandom % 4 == 0) begin
        nxmDataVal <= 1'b1;
      end else if (isRead) begin
        memDataValidA <= exp[1];
        memDataValidB <= exp[0];
      end
      @(negedge clk);
      checkBit("acknPulse", acknPulse, 1'b1);
      @(posedge clk);
      {memAcknA, memAcknB, nxmAckn} <= 3'b000;
      {memDataValidA, memDataValidB, nxmDataVal} <= 3'b000;
      @(negedge clk);
      checkBit("memStart", memStartA | memStartB, k < n);
      checkMask("memRq", memRq, mask);
      if (isRead) begin
        checkBit("coreRdInProg", coreRdInProg, 1'b1);
        checkAdr("coreAdr", coreAdr, expAdr);
        if (k < n) begin
          expAdr = refNextAdr(expAdr);
        end
      end
    end
    if (isRead) begin
      repeat (2) @(negedge clk);
      checkBit("coreRdInProg", coreRdInProg, 1'b0);
      checkAdr("coreAdr", coreAdr, expAdr);
    end
  endtask

  initial begin
    void'($urandom(36));
    arstN = 1'b0;
    {coreRdRq, startMem, anyRqIn, rdRqIn, wrRqIn} = '0;
    rqIn = '0;
    sbusAdr = '0;
    {adrParIn, wrBadAdrPar, memAcknA, memAcknB, nxmAckn} = '0;
    {memDataValidA, memDataValidB, nxmDataVal} = '0;
    repeat (2) @(posedge clk);
    arstN <= 1'b1;
    repeat (10) @(posedge clk);
    if (firstStrobe < 0) begin
      $display("No phase strobe appeared after reset was released");
      $display("Simulation FAILED");
      $fatal(1, "Phase generator did not start");
    end
    for (int i = 0; i < NumTxn; i++) begin
      runTxn(1'($urandom));
    end
    repeat (6) @(posedge clk);
    $display("Simulation PASSED");
    $finish;
  end

  initial begin
    #(ClkPeriod * (NumTxn * TxnCycles + Margin));
    $display("Timeout: the transactions did not finish in time");
    $display("Simulation FAILED");
    $fatal(1, "Watchdog expired");
  end

endmodule

// File: sim.f
+incdir+bench
source/mbcPkg.sv
source/mbcIfs.sv
source/busPhaseGen.sv
source/memStartCtl.sv
source/sbusRequest.sv
source/coreReadSeq.sv
source/mbcTop.sv
bench/mbcTb.sv

// File: source/busPhaseGen.sv
// Memory bus phase generator giving the A/B phase and its change-coming strobes.
`timescale 1ns/1ps

module busPhaseGen (
  input logic clk,
  input logic arstN,
  phaseIf.source phase
);

  typedef logic [$clog2(mbcPkg::PhaseLen)-1:0] cntT;

  logic run;
  cntT halfCnt;
  mbcPkg::busPhaseT curPhase;
  logic lastCyc;
  logic preLast;
  logic aChangeQ;
  logic bChangeQ;

  assign lastCyc = halfCnt == cntT'(mbcPkg::PhaseLen - 1);

  // One cycle ahead of the last cycle of a half-phase, so the strobes can be registered.
  assign preLast = run && halfCnt == cntT'(mbcPkg::PhaseLen - 2);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      run <= 1'b0;
      halfCnt <= '0;
      curPhase <= mbcPkg::phaseA;
      aChangeQ <= 1'b0;
      bChangeQ <= 1'b0;
    end else begin
      // The sequencer starts one cycle after reset is released.
      run <= 1'b1;
      if (run) begin
        if (lastCyc) begin
          halfCnt <= '0;
          curPhase <= (curPhase == mbcPkg::phaseA) ? mbcPkg::phaseB : mbcPkg::phaseA;
        end else begin
          halfCnt <= halfCnt + cntT'(1);
        end
      end
      aChangeQ <= preLast && curPhase == mbcPkg::phaseB;
      bChangeQ <= preLast && curPhase == mbcPkg::phaseA;
    end
  end

  assign phase.aChangeComing = aChangeQ;
  assign phase.bChangeComing = bChangeQ;
  assign phase.phaseChangeComing = aChangeQ | bChangeQ;
  // A is the next phase for the whole of phase B.
  assign phase.aPhaseComing = curPhase == mbcPkg::phaseB;

  // Every A strobe is followed by a B strobe two cycles later, never in the same cycle.
  aThenB: assert property (@(posedge clk) disable iff (!arstN)
    phase.aChangeComing |-> !phase.bChangeComing ##2 phase.bChangeComing);

endmodule

// File: source/coreReadSeq.sv
// Core read sequencer with the data-valid delay, read-in-progress flag and word address counter.
`timescale 1ns/1ps

module coreReadSeq (
  input logic clk,
  input logic arstN,
  input logic memDataValidA,
  input logic memDataValidB,
  input logic nxmDataVal,
  input logic memStartRd,
  phaseIf.sink phase,
  heldRqIf.reader held,
  output logic coreDataValid,
  output logic coreRdInProg,
  output mbcPkg::wordAdrT coreAdr
);

  logic dvQual;
  logic [mbcPkg::DataValDelay-1:0] dvPipe;
  logic memStartRdQ;
  logic readBegin;
  mbcPkg::rqMaskT remWords;
  mbcPkg::rqMaskT remLeft;

  // Data-valid is sampled in the cycle before the change to its own phase.
  assign dvQual = (memDataValidA | nxmDataVal) & phase.aChangeComing |
                  (memDataValidB | nxmDataVal) & phase.bChangeComing;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      dvPipe <= '0;
    end else begin
      dvPipe <= {dvPipe[mbcPkg::DataValDelay-2:0], dvQual};
    end
  end

  assign coreDataValid = dvPipe[mbcPkg::DataValDelay-1];

  // First cycle of a read start.
  assign readBegin = memStartRd & ~memStartRdQ & held.memRdRq;

  assign remLeft = mbcPkg::dropLowest(remWords);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      memStartRdQ <= 1'b0;
      coreRdInProg <= 1'b0;
      remWords <= '0;
      coreAdr <= '0;
    end else begin
      memStartRdQ <= memStartRd;
      if (readBegin) begin
        coreAdr <= held.adr;
        remWords <= held.memRq;
        coreRdInProg <= held.memRq != '0;
      end else if (coreRdInProg && coreDataValid) begin
        remWords <= remLeft;
        if (remLeft != '0) begin
          // The quad-word wraps, so the address steps modulo four.
          coreAdr <= coreAdr + mbcPkg::wordAdrT'(1);
        end else begin
          coreRdInProg <= 1'b0;
        end
      end
    end
  end

  // Memory must not return data for a core read that is not in progress.
  dataInRead: assert property (@(posedge clk) disable iff (!arstN)
    coreDataValid |-> coreRdInProg);

endmodule

// File: source/mbcIfs.sv
// Phase strobe and held request interfaces shared by the memory bus control blocks.
`timescale 1ns/1ps

interface phaseIf;

  logic aChangeComing;
  logic bChangeComing;
  logic phaseChangeComing;
  logic aPhaseComing;

  modport source (
    output aChangeComing,
    output bChangeComing,
    output phaseChangeComing,
    output aPhaseComing
  );

  modport sink (
    input aChangeComing,
    input bChangeComing,
    input phaseChangeComing,
    input aPhaseComing
  );

endinterface

interface heldRqIf;

  mbcPkg::rqMaskT memRq;
  logic memRdRq;
  logic memWrRq;
  mbcPkg::wordAdrT adr;
  logic rqHold;
  logic lastAckn;

  // The request block holds the SBUS request and counts its acknowledges.
  modport request (
    output memRq,
    output memRdRq,
    output memWrRq,
    output adr,
    output lastAckn,
    input rqHold
  );

  modport start (
    output rqHold,
    input lastAckn
  );

  modport reader (
    input memRq,
    input memRdRq,
    input adr
  );

endinterface

// File: source/mbcPkg.sv
// Memory bus control package with the request widths, word address type and phase timing.
package mbcPkg;

  // Words in one memory request, one mask bit per word of the quad-word.
  localparam int RqWords = 4;

  // Clocks per half-phase of the memory bus cycle.
  localparam int PhaseLen = 2;

  // Clocks from a qualified memory data-valid to the core data-valid.
  localparam int DataValDelay = 2;

  typedef logic [RqWords-1:0] rqMaskT;

  // Word within the quad-word, the low two bits of the memory address.
  typedef logic [1:0] wordAdrT;

  typedef enum logic {
    phaseA = 1'b0,
    phaseB = 1'b1
  } busPhaseT;

  // Drops the lowest set bit of a request mask.
  // Acknowledges and core data words are both taken lowest word first.
  function automatic rqMaskT dropLowest(rqMaskT mask);
    rqMaskT below;
    below = mask - rqMaskT'(1);
    return mask & below;
  endfunction

endpackage

// File: source/mbcTop.sv
// Memory bus control top joining the phase generator, start control, request hold and core read.
`timescale 1ns/1ps

module mbcTop (
  input logic clk,
  input logic arstN,
  input logic coreRdRq,
  input logic startMem,
  input logic anyRqIn,
  input logic rdRqIn,
  input logic wrRqIn,
  input mbcPkg::rqMaskT rqIn,
  input mbcPkg::wordAdrT sbusAdr,
  input logic adrParIn,
  input logic wrBadAdrPar,
  input logic memAcknA,
  input logic memAcknB,
  input logic nxmAckn,
  input logic memDataValidA,
  input logic memDataValidB,
  input logic nxmDataVal,
  output logic memStartA,
  output logic memStartB,
  output logic acknPulse,
  output logic memAdrPar,
  output logic coreDataValid,
  output logic coreRdInProg,
  output mbcPkg::wordAdrT coreAdr,
  output logic aChangeComing,
  output logic bChangeComing,
  output mbcPkg::rqMaskT memRq,
  output logic memRdRq,
  output logic memWrRq
);

  logic memStart;
  logic memStartRd;

  phaseIf phaseBus ();
  heldRqIf heldRq ();

  busPhaseGen uPhase (
    .clk(clk),
    .arstN(arstN),
    .phase(phaseBus.source)
  );

  memStartCtl uStart (
    .clk(clk),
    .arstN(arstN),
    .coreRdRq(coreRdRq),
    .startMem(startMem),
    .anyRqIn(anyRqIn),
    .rdRqIn(rdRqIn),
    .memAcknA(memAcknA),
    .memAcknB(memAcknB),
    .nxmAckn(nxmAckn),
    .phase(phaseBus.sink),
    .held(heldRq.start),
    .memStartA(memStartA),
    .memStartB(memStartB),
    .memStart(memStart),
    .memStartRd(memStartRd),
    .acknPulse(acknPulse)
  );

  sbusRequest uRequest (
    .clk(clk),
    .arstN(arstN),
    .rqIn(rqIn),
    .sbusAdr(sbusAdr),
    .rdRqIn(rdRqIn),
    .wrRqIn(wrRqIn),
    .adrParIn(adrParIn),
    .wrBadAdrPar(wrBadAdrPar),
    .memStart(memStart),
    .acknPulse(acknPulse),
    .held(heldRq.request),
    .memAdrPar(memAdrPar)
  );

  coreReadSeq uCoreRead (
    .clk(clk),
    .arstN(arstN),
    .memDataValidA(memDataValidA),
    .memDataValidB(memDataValidB),
    .nxmDataVal(nxmDataVal),
    .memStartRd(memStartRd),
    .phase(phaseBus.sink),
    .held(heldRq.reader),
    .coreDataValid(coreDataValid),
    .coreRdInProg(coreRdInProg),
    .coreAdr(coreAdr)
  );

  assign aChangeComing = phaseBus.aChangeComing;
  assign bChangeComing = phaseBus.bChangeComing;
  assign memRq = heldRq.memRq;
  assign memRdRq = heldRq.memRdRq;
  assign memWrRq = heldRq.memWrRq;

endmodule

// File: source/memStartCtl.sv
// Memory start control arbitrating the start into bus phase A or B until the last acknowledge.
`timescale 1ns/1ps

module memStartCtl (
  input logic clk,
  input logic arstN,
  input logic coreRdRq,
  input logic startMem,
  input logic anyRqIn,
  input logic rdRqIn,
  input logic memAcknA,
  input logic memAcknB,
  input logic nxmAckn,
  phaseIf.sink phase,
  heldRqIf.start held,
  output logic memStartA,
  output logic memStartB,
  output logic memStart,
  output logic memStartRd,
  output logic acknPulse
);

  logic startCause;
  logic setA;
  logic setB;
  logic startClr;
  logic rdStart;

  assign startCause = coreRdRq | startMem | anyRqIn;

  // A new cause is ignored while either start is held.
  assign setA = phase.aChangeComing & startCause & ~memStart;
  assign setB = phase.bChangeComing & startCause & ~memStart;

  // The last acknowledge ends the start at once.
  assign startClr = held.lastAckn;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      memStartA <= 1'b0;
      memStartB <= 1'b0;
      rdStart <= 1'b0;
    end else begin
      memStartA <= setA | memStartA & ~startClr;
      memStartB <= setB | memStartB & ~startClr;
      if (setA || setB) begin
        rdStart <= rdRqIn;
      end
    end
  end

  assign memStart = memStartA | memStartB;
  assign memStartRd = memStart & rdStart;
  assign held.rqHold = memStart;

  // An acknowledge counts only in the cycle before the change to its own phase.
  // A non-existent memory acknowledge counts in either phase.
  assign acknPulse = phase.phaseChangeComing &
                     (phase.aPhaseComing ? (memAcknA | nxmAckn) : (memAcknB | nxmAckn));

  startsExclusive: assert property (@(posedge clk) disable iff (!arstN)
    !(memStartA && memStartB));

endmodule

// File: source/sbusRequest.sv
// SBUS request hold registers with acknowledge tracking and memory address parity.
`timescale 1ns/1ps

module sbusRequest (
  input logic clk,
  input logic arstN,
  input mbcPkg::rqMaskT rqIn,
  input mbcPkg::wordAdrT sbusAdr,
  input logic rdRqIn,
  input logic wrRqIn,
  input logic adrParIn,
  input logic wrBadAdrPar,
  input logic memStart,
  input logic acknPulse,
  heldRqIf.request held,
  output logic memAdrPar
);

  mbcPkg::rqMaskT ackMask;
  mbcPkg::rqMaskT ackLeft;
  logic adrParHold;
  logic forceBadPar;

  // The held request follows the SBUS inputs until a start holds it.
  always_ff @(posedge clk) begin
    if (!held.rqHold) begin
      held.memRq <= rqIn;
      held.memRdRq <= rdRqIn;
      held.memWrRq <= wrRqIn;
      held.adr <= sbusAdr;
      adrParHold <= adrParIn;
    end
  end

  assign ackLeft = mbcPkg::dropLowest(ackMask);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ackMask <= '0;
      forceBadPar <= 1'b0;
    end else begin
      if (!held.rqHold) begin
        ackMask <= rqIn;
      end else if (acknPulse) begin
        ackMask <= ackLeft;
      end
      // Bad parity is armed between starts and kept through the next one.
      forceBadPar <= wrBadAdrPar & ~memStart | memStart & forceBadPar;
    end
  end

  // The last acknowledge is the one that leaves no requested word behind it.
  assign held.lastAckn = acknPulse & (ackLeft == '0);

  assign memAdrPar = adrParHold ^
                     held.memRdRq ^
                     held.memWrRq ^
                     (^held.memRq) ^
                     (^held.adr) ^
                     forceBadPar;

endmodule
